/* common/execPkg.sv */
package execPkg;

  ////////////////////////////////////////////////////////////
  // Widths and saturation limits
  ////////////////////////////////////////////////////////////
  localparam int dataWidth  = 16;                     // Width of the whole data path
  localparam int regWidth   = 4;                      // Register numbers select 1 of 16
  localparam int shamtWidth = 4;                      // Shift immediate covers 0 to 15
  localparam int laneWidth  = 4;                      // One PADDSB lane
  localparam int laneCount  = dataWidth / laneWidth;  // Four lanes per word

  localparam logic [dataWidth-1:0] satMax  = 16'h7FFF; // Largest signed word
  localparam logic [dataWidth-1:0] satMin  = 16'h8000; // Smallest signed word
  localparam logic [laneWidth-1:0] laneMax = 4'h7;     // +7 clamp of a lane
  localparam logic [laneWidth-1:0] laneMin = 4'h8;     // -8 clamp of a lane

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////
  // Codes 8 to 15 are left out on purpose and act as pass-through
  typedef enum logic [3:0] {
    opAdd    = 4'd0,
    opSub    = 4'd1,
    opXor    = 4'd2,
    opRed    = 4'd3,
    opSll    = 4'd4,
    opSra    = 4'd5,
    opRor    = 4'd6,
    opPaddsb = 4'd7
  } opcodeT;

  // Same numbering as the shifter mode pins
  typedef enum logic [1:0] {
    shNone = 2'd0,
    shSll  = 2'd1,
    shSra  = 2'd2,
    shRor  = 2'd3
  } shiftModeT;

  // One instruction word read two ways
  typedef union packed {
    struct packed {
      opcodeT               opcode;
      logic [regWidth-1:0]  rd;
      logic [regWidth-1:0]  rs;
      logic [regWidth-1:0]  rt;
    } rType;                                          // Register form
    struct packed {
      opcodeT               opcode;
      logic [regWidth-1:0]  rd;
      logic [regWidth-1:0]  rs;
      logic [shamtWidth-1:0] imm;
    } iType;                                          // Shift form with immediate
  } instrT;

  typedef struct packed {
    logic zero;
    logic overflow;
    logic negative;
  } flagsT;

  // True for the three opcodes that take the immediate
  function automatic logic isShift(opcodeT op);
    return (op == opSll) || (op == opSra) || (op == opRor);
  endfunction

endpackage

/* common/aluOpIf.sv */
`timescale 1ns/100ps

// One decoded operation on its way from decode to the ALU stage
interface aluOpIf;

  logic                             valid;  // Operation present
  logic                             ready;  // ALU stage can take it
  execPkg::opcodeT                  op;     // Raw opcode, 8 to 15 included
  logic [execPkg::dataWidth-1:0]    a;      // First operand from rs
  logic [execPkg::dataWidth-1:0]    b;      // Second operand from rt or zero for shifts
  logic [execPkg::shamtWidth-1:0]   shamt;  // Shift amount or zero for register forms
  logic [execPkg::regWidth-1:0]     rd;     // Destination register number

  // Decode side drives the payload and valid
  modport producer (
    output valid, op, a, b, shamt, rd,
    input  ready
  );

  // ALU side answers with ready
  modport consumer (
    input  valid, op, a, b, shamt, rd,
    output ready
  );

endinterface

/* hdl/opDecode.sv */
`timescale 1ns/100ps

module opDecode (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          inValid,  // Instruction and operands present
  output logic                          inReady,  // Decode register can take them
  input  execPkg::instrT                instr,
  input  logic [execPkg::dataWidth-1:0] rsData,   // Value of register rs
  input  logic [execPkg::dataWidth-1:0] rtData,   // Value of register rt
  aluOpIf.producer                      opOut
);

  ////////////////////////////////////////////////////////////
  // Field split
  ////////////////////////////////////////////////////////////
  execPkg::opcodeT                 opcode;     // Same bits in both forms
  logic                            shiftOp;    // Instruction uses the immediate
  logic [execPkg::dataWidth-1:0]   bSel;       // Second operand after the select
  logic [execPkg::shamtWidth-1:0]  shamtSel;   // Shift amount after the select
  logic                            accept;     // Transfer on the input side

  // Stage register
  logic                            stageValid;
  execPkg::opcodeT                 opReg;
  logic [execPkg::dataWidth-1:0]   aReg;
  logic [execPkg::dataWidth-1:0]   bReg;
  logic [execPkg::shamtWidth-1:0]  shamtReg;
  logic [execPkg::regWidth-1:0]    rdReg;

  assign opcode  = instr.rType.opcode;
  assign shiftOp = execPkg::isShift(opcode);

  // Shifts read the low nibble as an immediate and ignore rt
  assign bSel     = shiftOp ? '0 : rtData;
  assign shamtSel = shiftOp ? instr.iType.imm : '0;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////
  // Free when empty or when the ALU stage drains us this cycle
  assign inReady = !stageValid || opOut.ready;
  assign accept  = inValid && inReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stageValid <= 1'b0;
    end else if (inReady) begin
      stageValid <= inValid;                  // Refill or go empty
    end
  end

  // Payload only moves on a transfer so it holds during a stall
  always_ff @(posedge clk) begin
    if (accept) begin
      opReg    <= opcode;
      aReg     <= rsData;                     // rs always feeds operand a
      bReg     <= bSel;
      shamtReg <= shamtSel;
      rdReg    <= instr.rType.rd;
    end
  end

  ////////////////////////////////////////////////////////////
  // Drive the interface
  ////////////////////////////////////////////////////////////
  assign opOut.valid = stageValid;
  assign opOut.op    = opReg;
  assign opOut.a     = aReg;
  assign opOut.b     = bReg;
  assign opOut.shamt = shamtReg;
  assign opOut.rd    = rdReg;

endmodule

/* alu/shifter.sv */
`timescale 1ns/100ps

// Barrel shifter in two 4:1 levels per operation
module shifter (
  input  logic [15:0]         shiftIn,   // Word to shift
  input  logic [3:0]          shiftVal,  // Shift amount 0 to 15
  input  execPkg::shiftModeT  mode,      // None, SLL, SRA or ROR
  output logic [15:0]         shiftOut
);

  logic [15:0] sllStep, sraStep, rorStep;  // After the 0 to 3 level
  logic [15:0] sllOut, sraOut, rorOut;     // After the 0/4/8/12 level
  logic        sign;                       // Fill bit for SRA

  assign sign = shiftIn[15];

  ////////////////////////////////////////////////////////////
  // Logical left
  ////////////////////////////////////////////////////////////
  assign sllStep = (shiftVal[1:0] == 2'd0) ? shiftIn               :
                   (shiftVal[1:0] == 2'd1) ? {shiftIn[14:0], 1'b0} :
                   (shiftVal[1:0] == 2'd2) ? {shiftIn[13:0], 2'b0} :
                                             {shiftIn[12:0], 3'b0};

  assign sllOut = (shiftVal[3:2] == 2'd0) ? sllStep                :
                  (shiftVal[3:2] == 2'd1) ? {sllStep[11:0], 4'h0}  :
                  (shiftVal[3:2] == 2'd2) ? {sllStep[7:0], 8'h00}  :
                                            {sllStep[3:0], 12'h000};

  ////////////////////////////////////////////////////////////
  // Arithmetic right
  ////////////////////////////////////////////////////////////
  // The first level keeps bit 15 so the second level can copy it again
  assign sraStep = (shiftVal[1:0] == 2'd0) ? shiftIn                    :
                   (shiftVal[1:0] == 2'd1) ? {sign, shiftIn[15:1]}      :
                   (shiftVal[1:0] == 2'd2) ? {{2{sign}}, shiftIn[15:2]} :
                                             {{3{sign}}, shiftIn[15:3]};

  assign sraOut = (shiftVal[3:2] == 2'd0) ? sraStep                      :
                  (shiftVal[3:2] == 2'd1) ? {{4{sign}}, sraStep[15:4]}   :
                  (shiftVal[3:2] == 2'd2) ? {{8{sign}}, sraStep[15:8]}   :
                                            {{12{sign}}, sraStep[15:12]};

  ////////////////////////////////////////////////////////////
  // Rotate right
  ////////////////////////////////////////////////////////////
  assign rorStep = (shiftVal[1:0] == 2'd0) ? shiftIn                         :
                   (shiftVal[1:0] == 2'd1) ? {shiftIn[0], shiftIn[15:1]}     :
                   (shiftVal[1:0] == 2'd2) ? {shiftIn[1:0], shiftIn[15:2]}   :
                                             {shiftIn[2:0], shiftIn[15:3]};

  // Low bits wrap to the top by 4, 8 or 12
  assign rorOut = (shiftVal[3:2] == 2'd0) ? rorStep                         :
                  (shiftVal[3:2] == 2'd1) ? {rorStep[3:0], rorStep[15:4]}   :
                  (shiftVal[3:2] == 2'd2) ? {rorStep[7:0], rorStep[15:8]}   :
                                            {rorStep[11:0], rorStep[15:12]};

  always_comb begin
    case (mode)
      execPkg::shSll: shiftOut = sllOut;
      execPkg::shSra: shiftOut = sraOut;
      execPkg::shRor: shiftOut = rorOut;
      default:        shiftOut = shiftIn;  // shNone leaves the word alone
    endcase
  end

endmodule

/* alu/satAdder.sv */
`timescale 1ns/100ps

// Saturating add and subtract plus the two lane operations
module satAdder (
  input  logic [execPkg::dataWidth-1:0] a,
  input  logic [execPkg::dataWidth-1:0] b,
  input  execPkg::opcodeT               op,
  output logic [execPkg::dataWidth-1:0] sum,
  output logic                          sat   // Word result was clamped
);

  logic                            subtract;  // Invert b and carry in one
  logic [execPkg::dataWidth-1:0]   bOperand;
  logic [execPkg::dataWidth-1:0]   rawSum;    // Wrapped two's complement result
  logic                            overflow;  // Signed overflow of rawSum
  logic [execPkg::dataWidth-1:0]   clamped;
  logic [execPkg::dataWidth-1:0]   laneOut;   // PADDSB result
  logic [execPkg::dataWidth-1:0]   redSum;    // RED result

  ////////////////////////////////////////////////////////////
  // Word add and subtract
  ////////////////////////////////////////////////////////////
  assign subtract = (op == execPkg::opSub);
  assign bOperand = subtract ? ~b : b;
  assign rawSum   = a + bOperand + {{(execPkg::dataWidth-1){1'b0}}, subtract};

  // Same input signs and a flipped result sign mean overflow
  assign overflow = (a[15] == bOperand[15]) && (rawSum[15] != a[15]);
  assign clamped  = a[15] ? execPkg::satMin : execPkg::satMax;  // Direction follows a

  ////////////////////////////////////////////////////////////
  // PADDSB lanes
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < execPkg::laneCount; i++) begin : genLane
    logic [execPkg::laneWidth-1:0] laneA;
    logic [execPkg::laneWidth-1:0] laneB;
    logic [execPkg::laneWidth:0]   laneWide;  // One guard bit

    assign laneA    = a[i*execPkg::laneWidth +: execPkg::laneWidth];
    assign laneB    = b[i*execPkg::laneWidth +: execPkg::laneWidth];
    assign laneWide = {laneA[execPkg::laneWidth-1], laneA}
                    + {laneB[execPkg::laneWidth-1], laneB};

    // Guard and sign disagree only when the lane left -8..+7
    assign laneOut[i*execPkg::laneWidth +: execPkg::laneWidth] =
      (laneWide[execPkg::laneWidth] == laneWide[execPkg::laneWidth-1]) ?
        laneWide[execPkg::laneWidth-1:0] :
      (laneWide[execPkg::laneWidth] ? execPkg::laneMin : execPkg::laneMax);
  end

  ////////////////////////////////////////////////////////////
  // RED byte reduction
  ////////////////////////////////////////////////////////////
  // Four bytes of at most 8 bits each never reach bit 15, so no clamp
  always_comb begin
    redSum = '0;
    for (int i = 0; i < execPkg::dataWidth / 8; i++) begin
      redSum = redSum + {{8{a[8*i+7]}}, a[8*i +: 8]} + {{8{b[8*i+7]}}, b[8*i +: 8]};
    end
  end

  always_comb begin
    sat = 1'b0;
    case (op)
      execPkg::opAdd,
      execPkg::opSub: begin
        sum = overflow ? clamped : rawSum;
        sat = overflow;
      end
      execPkg::opPaddsb: sum = laneOut;
      execPkg::opRed:    sum = redSum;
      default:           sum = rawSum;  // Not selected by the ALU
    endcase
  end

endmodule

/* alu/aluCore.sv */
`timescale 1ns/100ps

module aluCore (
  input  logic                          clk,
  input  logic                          rstN,
  aluOpIf.consumer                      opIn,
  output logic                          outValid,
  input  logic                          outReady,
  output logic [execPkg::dataWidth-1:0] outResult,
  output logic [execPkg::regWidth-1:0]  outRd,
  output execPkg::flagsT                outFlags
);

  execPkg::shiftModeT             shMode;
  logic [execPkg::dataWidth-1:0]  shiftResult;
  logic [execPkg::dataWidth-1:0]  addSum;
  logic                           addSat;
  logic [execPkg::dataWidth-1:0]  xorResult;
  logic [execPkg::dataWidth-1:0]  result;      // Selected by opcode
  logic                           updZero;     // Zero flag follows this op
  logic                           updArith;    // Overflow and negative follow too
  execPkg::flagsT                 nextFlags;
  execPkg::flagsT                 flagReg;
  logic                           accept;

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////
  // Everything that is not a shift runs the shifter in none mode
  always_comb begin
    case (opIn.op)
      execPkg::opSll: shMode = execPkg::shSll;
      execPkg::opSra: shMode = execPkg::shSra;
      execPkg::opRor: shMode = execPkg::shRor;
      default:        shMode = execPkg::shNone;
    endcase
  end

  shifter iShifter (
    .shiftIn  (opIn.a),
    .shiftVal (opIn.shamt),
    .mode     (shMode),
    .shiftOut (shiftResult)
  );

  satAdder iSatAdder (
    .a   (opIn.a),
    .b   (opIn.b),
    .op  (opIn.op),
    .sum (addSum),
    .sat (addSat)
  );

  assign xorResult = opIn.a ^ opIn.b;

  always_comb begin
    result    = shiftResult;  // Also the pass-through value for codes 8 to 15
    updZero   = 1'b1;
    updArith  = 1'b0;
    case (opIn.op)
      execPkg::opAdd,
      execPkg::opSub: begin
        result   = addSum;
        updArith = 1'b1;
      end
      execPkg::opXor:    result = xorResult;
      execPkg::opRed,
      execPkg::opPaddsb: result = addSum;
      execPkg::opSll,
      execPkg::opSra,
      execPkg::opRor:    result = shiftResult;
      default:           updZero = 1'b0;  // Pass-through keeps every flag
    endcase

    nextFlags = flagReg;
    if (updZero) nextFlags.zero = (result == '0);
    if (updArith) begin
      nextFlags.overflow = addSat;          // Overflow means the word saturated
      nextFlags.negative = result[15];
    end
  end

  ////////////////////////////////////////////////////////////
  // Output register and flags
  ////////////////////////////////////////////////////////////
  assign opIn.ready = !outValid || outReady;   // Empty or draining this cycle
  assign accept     = opIn.valid && opIn.ready;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      flagReg  <= '0;
    end else begin
      if (opIn.ready) outValid <= opIn.valid;
      if (accept)     flagReg  <= nextFlags;  // Changes together with the result
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      outResult <= result;
      outRd     <= opIn.rd;
    end
  end

  // Flags are only written on a transfer, so they match the held result
  assign outFlags = flagReg;

endmodule

/* hdl/execUnit.sv */
`timescale 1ns/100ps

// Execute unit with a decode stage and an ALU stage
module execUnit (
  input  logic                          clk,
  input  logic                          rstN,

  // Instruction side
  input  logic                          inValid,
  output logic                          inReady,
  input  execPkg::instrT                instr,
  input  logic [execPkg::dataWidth-1:0] rsData,
  input  logic [execPkg::dataWidth-1:0] rtData,

  // Result side
  output logic                          outValid,
  input  logic                          outReady,
  output logic [execPkg::dataWidth-1:0] outResult,
  output logic [execPkg::regWidth-1:0]  outRd,
  output execPkg::flagsT                outFlags
);

  ////////////////////////////////////////////////////////////
  // Stage link
  ////////////////////////////////////////////////////////////
  aluOpIf aluOp ();  // Decoded operation between the stages

  opDecode iOpDecode (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .instr   (instr),
    .rsData  (rsData),
    .rtData  (rtData),
    .opOut   (aluOp.producer)
  );

  // Second stage holds the result and the flag register
  aluCore iAluCore (
    .clk       (clk),
    .rstN      (rstN),
    .opIn      (aluOp.consumer),
    .outValid  (outValid),
    .outReady  (outReady),
    .outResult (outResult),
    .outRd     (outRd),
    .outFlags  (outFlags)
  );

endmodule

/* sim/tbClock.sv */
`timescale 1ns/100ps

// Free running clock and a short reset at the start
module tbClock (
  output logic clk,
  output logic rstN
);

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);  // Two rising edges see reset low
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

/* sim/execModel.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////
// Classic 13/17/5 xorshift on 32 bits
function automatic logic [31:0] xorshift(input logic [31:0] x);
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// Clamp a signed sum into the range lo..hi and report the clamp
function automatic int clampInt(input int v, input int lo, input int hi, output logic hit);
  hit = 1'b0;
  if (v > hi) begin
    hit = 1'b1;
    return hi;
  end
  if (v < lo) begin
    hit = 1'b1;
    return lo;
  end
  return v;
endfunction

////////////////////////////////////////////////////////////
// Reference model of one instruction
////////////////////////////////////////////////////////////
function automatic logic [15:0] refExec(input logic [15:0] ins, input logic [15:0] rs,
                                        input logic [15:0] rt, input execPkg::flagsT oldF,
                                        output execPkg::flagsT newF);
  logic [3:0]  op;
  logic [3:0]  imm;
  logic [15:0] res;
  logic [31:0] twice;
  logic        hit;
  int          acc;
  int          lane;
  op    = ins[15:12];
  imm   = ins[3:0];                       // Low nibble is the shift amount
  newF  = oldF;
  res   = rs;                             // Codes 8 to 15 pass rs through
  hit   = 1'b0;
  twice = {rs, rs};
  case (op)
    4'd0: res = 16'(clampInt(int'($signed(rs)) + int'($signed(rt)), -32768, 32767, hit));
    4'd1: res = 16'(clampInt(int'($signed(rs)) - int'($signed(rt)), -32768, 32767, hit));
    4'd2: res = rs ^ rt;
    4'd3: begin
      acc = 0;
      for (int i = 0; i < 2; i++) begin
        acc = acc + int'($signed(rs[8*i +: 8])) + int'($signed(rt[8*i +: 8]));
      end
      res = 16'(acc);
    end
    4'd4: res = rs << imm;
    4'd5: res = $signed(rs) >>> imm;
    4'd6: res = 16'(twice >> imm);        // Doubled word makes the wrap easy
    4'd7: begin
      for (int i = 0; i < 4; i++) begin
        lane = int'($signed(rs[4*i +: 4])) + int'($signed(rt[4*i +: 4]));
        res[4*i +: 4] = 4'(clampInt(lane, -8, 7, hit));
      end
      hit = 1'b0;                         // Lane clamps do not touch overflow
    end
    default: ;
  endcase
  if (op < 4'd8) newF.zero = (res == 16'h0000);
  if (op < 4'd2) begin
    newF.overflow = hit;
    newF.negative = res[15];
  end
  return res;
endfunction

`endif

/* sim/tbExec.sv */
`timescale 1ns/100ps

module tbExec;

  `include "execModel.svh"

  localparam int totalInstr = 700;  // Upper bound of instructions over all tests

  logic clk, rstN, inValid, inReady, outValid, outReady;
  execPkg::instrT instr;
  logic [15:0] rsData, rtData, outResult;
  logic [3:0] outRd;
  execPkg::flagsT outFlags;

  logic [31:0] rngState = 32'h0e202cf9;
  logic [31:0] stallState = ~32'h0e202cf9;  // Own stream for the output stall pattern
  logic stallOn = 1'b0;            // Random outReady in the back-pressure test
  execPkg::flagsT modelFlags = '0;
  logic [15:0] expResult[$];
  logic [3:0] expRd[$];
  execPkg::flagsT expFlags[$];
  int errors = 0, testErrors = 0, sentCount = 0, passTests = 0, failTests = 0;

  tbClock iClock (.clk(clk), .rstN(rstN));

  execUnit i_execUnit (
    .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .instr(instr),
    .rsData(rsData), .rtData(rtData), .outValid(outValid), .outReady(outReady),
    .outResult(outResult), .outRd(outRd), .outFlags(outFlags)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic logic [15:0] makeInstr(input int op, input int rd, input int rs,
                                            input int rt);
    return {4'(op), 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  task automatic noteError();
    errors++;
    testErrors++;
  endtask

  task automatic compareData(input logic [15:0] act, input logic [15:0] exp, input string name);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      noteError();
    end
  endtask

  task automatic compareRd(input logic [3:0] act, input logic [3:0] exp, input string name);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      noteError();
    end
  endtask

  task automatic compareFlags(input execPkg::flagsT act, input execPkg::flagsT exp,
                              input string name);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      noteError();
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic sendInstr(input logic [15:0] ins, input logic [15:0] rs, input logic [15:0] rt);
    logic [15:0] res;
    execPkg::flagsT nf;
    inValid = 1'b1;
    instr   = ins;
    rsData  = rs;
    rtData  = rt;
    do @(posedge clk); while (!inReady);  // Pre-edge value decides the transfer
    res = refExec(ins, rs, rt, modelFlags, nf);
    modelFlags = nf;
    expResult.push_back(res);
    expRd.push_back(ins[11:8]);
    expFlags.push_back(nf);
    sentCount++;
    @(negedge clk);
    inValid = 1'b0;
  endtask

  task automatic finishTest(input int num, input string name);
    while (expRd.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);             // Room for a stray output to show up
    $display("Test %0d %s finished: %0d errors", num, name, testErrors);
    if (testErrors == 0) passTests++;
    else failTests++;
    testErrors = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare process and output stall
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (rstN && outValid && outReady) begin
      if (expRd.size() == 0) begin
        $display("Output at %0t with no instruction pending", $time);
        noteError();
      end else begin
        compareData(outResult, expResult.pop_front(), "outResult");
        compareRd(outRd, expRd.pop_front(), "outRd");
        compareFlags(outFlags, expFlags.pop_front(), "outFlags");
      end
    end
  end

  always @(negedge clk) begin
    if (stallOn) begin
      stallState = xorshift(stallState);
      outReady   = (stallState[1:0] != 2'd0);  // Ready three cycles out of four
    end else begin
      outReady = 1'b1;
    end
  end

  // Hang guard sized from the instruction budget
  initial begin
    #(40.0 * (totalInstr * 4 + 200));
    $display("Run hung: outputs stopped before all tests were done");
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    logic [15:0] edges[3];
    logic [31:0] r;
    logic [31:0] ops;
    edges = '{16'h8000, 16'h0001, 16'hFFFF};
    inValid = 1'b0;
    instr = '0;
    rsData = '0;
    rtData = '0;
    outReady = 1'b1;
    @(posedge rstN);
    @(negedge clk);

    // Test 1 checks the state right after reset
    if (outValid !== 1'b0) begin
      $display("[FAIL] %0t outValid expected 0 got %b", $time, outValid);
      noteError();
    end
    if (inReady !== 1'b1) begin
      $display("[FAIL] %0t inReady expected 1 got %b", $time, inReady);
      noteError();
    end
    sendInstr(makeInstr(0, 1, 2, 3), 16'h0000, 16'h0000);
    while (expRd.size() != 0) @(negedge clk);
    compareFlags(outFlags, 3'b100, "outFlags");  // Zero set, overflow and negative clear
    finishTest(1, "reset");

    // Test 2 runs every shift amount on edge and random words
    for (int op = 4; op <= 6; op++) begin
      for (int amt = 0; amt < 16; amt++) begin
        for (int k = 0; k < 4; k++) begin
          r = nextRand();
          sendInstr(makeInstr(op, amt, 5, amt), (k < 3) ? edges[k] : r[15:0], r[31:16]);
        end
      end
    end
    finishTest(2, "shifts");

    // Test 3 drives ADD, SUB, PADDSB and RED to their signed limits
    sendInstr(makeInstr(0, 1, 0, 0), 16'h7FFF, 16'h0001);
    sendInstr(makeInstr(0, 2, 0, 0), 16'h8000, 16'hFFFF);
    sendInstr(makeInstr(1, 3, 0, 0), 16'h8000, 16'h0001);
    sendInstr(makeInstr(1, 4, 0, 0), 16'h7FFF, 16'hFFFF);
    sendInstr(makeInstr(0, 5, 0, 0), 16'h1234, 16'h0101);
    sendInstr(makeInstr(7, 6, 0, 0), 16'h7777, 16'h1111);
    sendInstr(makeInstr(7, 7, 0, 0), 16'h8888, 16'h8888);
    sendInstr(makeInstr(7, 8, 0, 0), 16'h7A18, 16'h1F8E);
    sendInstr(makeInstr(3, 9, 0, 0), 16'h7F7F, 16'h7F7F);
    sendInstr(makeInstr(3, 10, 0, 0), 16'h8080, 16'h8080);
    for (int i = 0; i < 30; i++) begin
      r = nextRand();
      sendInstr(makeInstr((i % 4 == 2) ? 7 : i % 4, i, 0, 0), r[15:0], r[31:16]);
    end
    finishTest(3, "arithmetic");

    // Test 4 shows that only the specified flags follow each opcode
    sendInstr(makeInstr(0, 1, 0, 0), 16'h7FFF, 16'h7FFF);
    sendInstr(makeInstr(2, 2, 0, 0), 16'h5A5A, 16'h5A5A);
    sendInstr(makeInstr(9, 3, 0, 0), 16'h0000, 16'h1234);
    sendInstr(makeInstr(4, 4, 0, 15), 16'h0001, 16'h0000);
    sendInstr(makeInstr(15, 5, 0, 0), 16'h0000, 16'h0000);
    sendInstr(makeInstr(1, 6, 0, 0), 16'h0005, 16'h0005);
    sendInstr(makeInstr(6, 7, 0, 3), 16'h8001, 16'h0000);
    sendInstr(makeInstr(12, 8, 0, 0), 16'hFFFF, 16'h0000);
    sendInstr(makeInstr(1, 9, 0, 0), 16'h8000, 16'h0001);
    sendInstr(makeInstr(5, 10, 0, 2), 16'h0000, 16'h0000);
    finishTest(4, "flag rule");

    // Test 5 sends a random stream with gaps on both sides
    stallOn = 1'b1;
    for (int i = 0; i < 400; i++) begin
      r = nextRand();
      ops = nextRand();
      if (r[0]) @(negedge clk);            // Idle cycle before this one
      sendInstr(r[31:16], ops[15:0], ops[31:16]);
    end
    finishTest(5, "back-pressure");
    stallOn = 1'b0;

    $display("Tests passed %0d, failed %0d, errors %0d, instructions %0d",
             passTests, failTests, errors, sentCount);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* execUnit.f */
+incdir+sim
common/execPkg.sv
common/aluOpIf.sv
hdl/opDecode.sv
alu/shifter.sv
alu/satAdder.sv
alu/aluCore.sv
hdl/execUnit.sv
sim/tbClock.sv
sim/tbExec.sv
